// ==== hw/cnn_pkg.sv ====
package cnn_pkg;

   ////////////////////
   // E4M3 format
   ////////////////////

   // Field widths of one minifloat
   localparam int FP8_W     = 8;
   localparam int FP8_EXP_W = 4;
   localparam int FP8_MAN_W = 3;

   // Exponent bias of the format
   localparam int FP8_EXP_BIAS = 7;

   // Largest exponent field, all ones, still a normal number
   localparam int FP8_EXP_MAX = 2 * FP8_EXP_BIAS + 1;

   // Saturation magnitude, exponent 15 with mantissa 7
   localparam logic [FP8_W-2:0] FP8_MAX_MAG = 7'h7F;

   // Positive zero, also the flushed result
   localparam logic [FP8_W-1:0] FP8_ZERO = 8'h00;

   ////////////////////
   // Types
   ////////////////////

   // One packed minifloat, sign at the top
   typedef logic [FP8_W-1:0] fp8_t;

   // Raw exponent field
   typedef logic [FP8_EXP_W-1:0] fp8_exp_t;

   // Raw mantissa field, hidden bit not included
   typedef logic [FP8_MAN_W-1:0] fp8_man_t;

   // Slice sequencer states
   typedef enum logic [1:0] {
      SEQ_IDLE   = 2'd0,
      SEQ_ACCUM  = 2'd1,
      SEQ_BIAS   = 2'd2,
      SEQ_FINISH = 2'd3
   } seq_state_t;

endpackage

// ==== hw/acc_ctrl_if.sv ====
`timescale 1ns/100ps

// Accumulation strobes, one sequencer to many lanes
interface acc_ctrl_if;

   // Zero the running sums
   logic clear;
   // Add the current depth slice
   logic accumulate;
   // Add the filter bias
   logic add_bias;
   // Lane sums are final
   logic finish;

   modport seq (
      output clear,
      output accumulate,
      output add_bias,
      output finish
   );

   modport lane (
      input clear,
      input accumulate,
      input add_bias,
      input finish
   );

endinterface

// ==== hw/fp8_adder.sv ====
`timescale 1ns/100ps

module fp8_adder
   import cnn_pkg::*;
(
   input  fp8_t a_i,
   input  fp8_t b_i,
   output fp8_t sum_o
);

   // Exponent window of a normal result
   localparam logic signed [5:0] EXP_TOP = 6'(FP8_EXP_MAX);

   logic              a_zero;
   logic              b_zero;
   logic [6:0]        mag_a;
   logic [6:0]        mag_b;
   logic              a_big;
   logic              s_big;
   logic              s_sml;
   fp8_exp_t          e_big;
   fp8_exp_t          e_sml;
   fp8_exp_t          e_diff;
   fp8_man_t          m_big;
   fp8_man_t          m_sml;
   fp8_man_t          m_res;
   logic [6:0]        sig_big;
   logic [6:0]        sig_sml;
   logic [6:0]        sig_aln;
   logic [7:0]        sum_w;
   logic [7:0]        norm_w;
   logic [2:0]        lead;
   logic signed [5:0] exp_res;

   ////////////////////
   // Unpack and order
   ////////////////////

   // Exponent field zero reads as zero, denormals included
   assign a_zero = (a_i[6:3] == '0);
   assign b_zero = (b_i[6:3] == '0);
   assign mag_a  = a_zero ? 7'd0 : a_i[6:0];
   assign mag_b  = b_zero ? 7'd0 : b_i[6:0];

   assign a_big = (mag_a >= mag_b);
   assign s_big = a_big ? a_i[7] : b_i[7];
   assign s_sml = a_big ? b_i[7] : a_i[7];
   assign e_big = a_big ? mag_a[6:3] : mag_b[6:3];
   assign e_sml = a_big ? mag_b[6:3] : mag_a[6:3];
   assign m_big = a_big ? mag_a[2:0] : mag_b[2:0];
   assign m_sml = a_big ? mag_b[2:0] : mag_a[2:0];

   // Hidden bit, mantissa and three guard bits
   assign sig_big = (e_big == '0) ? 7'd0 : {1'b1, m_big, 3'b000};
   assign sig_sml = (e_sml == '0) ? 7'd0 : {1'b1, m_sml, 3'b000};

   // Bits shifted past the guard bits are dropped
   assign e_diff  = e_big - e_sml;
   assign sig_aln = sig_sml >> e_diff;

   // Magnitude of the larger operand always wins, so no borrow out
   assign sum_w = (s_big == s_sml) ? ({1'b0, sig_big} + {1'b0, sig_aln})
                                   : ({1'b0, sig_big} - {1'b0, sig_aln});

   ////////////////////
   // Normalize
   ////////////////////

   // Highest set bit of the raw sum
   always_comb begin
      lead = '0;
      for (int i = 0; i < 8; i++) begin
         if (sum_w[i]) begin
            lead = 3'(i);
         end
      end
   end

   // Leading one moved to bit 7, lower bits truncated
   assign norm_w = sum_w << (3'd7 - lead);
   assign m_res  = norm_w[6:4];

   // Bit 6 of the raw sum is the unit position of e_big
   assign exp_res = $signed({2'b00, e_big}) + $signed({3'b000, lead}) - 6'sd6;

   always_comb begin
      if (sum_w == '0 || exp_res < 6'sd1) begin
         // Cancellation and underflow both give +0
         sum_o = FP8_ZERO;
      end else if (exp_res > EXP_TOP) begin
         sum_o = {s_big, FP8_MAX_MAG};
      end else begin
         sum_o = {s_big, fp8_exp_t'(exp_res[3:0]), m_res};
      end
   end

endmodule

// ==== hw/slice_sequencer.sv ====
`timescale 1ns/100ps

module slice_sequencer
   import cnn_pkg::*;
#(
   parameter int D = 4,
   parameter int H = 24,
   parameter int K = 8
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   done_convmul_i,
   input  logic [0:D*H*K*FP8_W-1] output_convmul_i,
   input  logic [0:K*FP8_W-1]     bias_i,
   acc_ctrl_if.seq                ctrl,
   output fp8_t                   lane_operand_o [K][H]
);

   localparam int CNT_W = (D > 1) ? $clog2(D) : 1;
   localparam logic [CNT_W-1:0] LAST_SLICE = CNT_W'(D - 1);

   seq_state_t       state_q;
   logic [CNT_W-1:0] depth_q;
   logic             clear_q;
   logic             accum_q;
   logic             add_bias_q;
   logic             finish_q;
   fp8_t             tensor_q [K][D][H];
   fp8_t             bias_val_q [K];

   ////////////////////
   // Input capture
   ////////////////////

   // A new strobe always recaptures, even mid job
   always_ff @(posedge clk) begin
      if (done_convmul_i) begin
         for (int k = 0; k < K; k++) begin
            for (int d = 0; d < D; d++) begin
               for (int j = 0; j < H; j++) begin
                  tensor_q[k][d][j] <= output_convmul_i[((k*D+d)*H+j)*FP8_W +: FP8_W];
               end
            end
            bias_val_q[k] <= bias_i[k*FP8_W +: FP8_W];
         end
      end
   end

   ////////////////////
   // Control FSM
   ////////////////////

   // Strobes are one-cycle pulses, cleared unless set below
   always_ff @(posedge clk or posedge rst_n) begin
      if (rst_n) begin
         state_q    <= SEQ_IDLE;
         depth_q    <= '0;
         clear_q    <= 1'b0;
         accum_q    <= 1'b0;
         add_bias_q <= 1'b0;
         finish_q   <= 1'b0;
      end else begin
         clear_q    <= 1'b0;
         accum_q    <= 1'b0;
         add_bias_q <= 1'b0;
         finish_q   <= 1'b0;
         if (done_convmul_i) begin
            state_q <= SEQ_ACCUM;
            depth_q <= '0;
            clear_q <= 1'b1;
         end else begin
            case (state_q)
               SEQ_ACCUM: begin
                  accum_q <= 1'b1;
                  if (depth_q == LAST_SLICE) begin
                     depth_q <= '0;
                     state_q <= SEQ_BIAS;
                  end else begin
                     depth_q <= depth_q + 1'b1;
                  end
               end
               SEQ_BIAS: begin
                  add_bias_q <= 1'b1;
                  state_q    <= SEQ_FINISH;
               end
               SEQ_FINISH: begin
                  finish_q <= 1'b1;
                  state_q  <= SEQ_IDLE;
               end
               default: state_q <= SEQ_IDLE;
            endcase
         end
      end
   end

   // Operand rows lag the state by one cycle, aligned with the strobes
   always_ff @(posedge clk) begin
      for (int k = 0; k < K; k++) begin
         for (int j = 0; j < H; j++) begin
            if (state_q == SEQ_ACCUM) begin
               lane_operand_o[k][j] <= tensor_q[k][depth_q][j];
            end else if (state_q == SEQ_BIAS) begin
               lane_operand_o[k][j] <= bias_val_q[k];
            end
         end
      end
   end

   assign ctrl.clear      = clear_q;
   assign ctrl.accumulate = accum_q;
   assign ctrl.add_bias   = add_bias_q;
   assign ctrl.finish     = finish_q;

   a_acc_bias_excl: assert property (@(posedge clk) disable iff (rst_n)
      !(ctrl.accumulate && ctrl.add_bias));

   // Bias step is followed by finish unless a restart intervenes
   a_bias_then_finish: assert property (@(posedge clk) disable iff (rst_n)
      ctrl.add_bias |=> (ctrl.finish || ctrl.clear));

endmodule

// ==== hw/filter_accumulator.sv ====
`timescale 1ns/100ps

module filter_accumulator
   import cnn_pkg::*;
#(
   parameter int H = 24
) (
   input  logic     clk,
   input  logic     rst_n,
   acc_ctrl_if.lane ctrl,
   input  fp8_t     operand_i [H],
   output fp8_t     lane_sum_o [H]
);

   fp8_t sum_q [H];
   fp8_t add_w [H];

   ////////////////////
   // Column adders
   ////////////////////

   for (genvar j = 0; j < H; j++) begin : g_col
      fp8_adder u_add (
         .a_i   (operand_i[j]),
         .b_i   (sum_q[j]),
         .sum_o (add_w[j])
      );
   end

   ////////////////////
   // Running sums
   ////////////////////

   // Slice and bias steps share the same adders
   always_ff @(posedge clk or posedge rst_n) begin
      if (rst_n) begin
         for (int j = 0; j < H; j++) begin
            sum_q[j] <= FP8_ZERO;
         end
      end else if (ctrl.clear) begin
         for (int j = 0; j < H; j++) begin
            sum_q[j] <= FP8_ZERO;
         end
      end else if (ctrl.accumulate || ctrl.add_bias) begin
         for (int j = 0; j < H; j++) begin
            sum_q[j] <= add_w[j];
         end
      end
   end

   assign lane_sum_o = sum_q;

   // Strobes come from the sequencer
   a_clear_not_acc: assert property (@(posedge clk) disable iff (rst_n)
      !(ctrl.clear && ctrl.accumulate));

endmodule

// ==== hw/result_collector.sv ====
`timescale 1ns/100ps

module result_collector
   import cnn_pkg::*;
#(
   parameter int H = 24,
   parameter int K = 8
) (
   input  logic                 clk,
   input  logic                 rst_n,
   acc_ctrl_if.lane             ctrl,
   input  fp8_t                 lane_sum_i [K][H],
   output logic [0:H*K*FP8_W-1] output_add_o,
   output logic                 done_add_o
);

   ////////////////////
   // Output row
   ////////////////////

   // Byte k*H+j holds column j of filter k, held until the next finish
   always_ff @(posedge clk or posedge rst_n) begin
      if (rst_n) begin
         output_add_o <= '0;
         done_add_o   <= 1'b0;
      end else begin
         done_add_o <= ctrl.finish;
         if (ctrl.finish) begin
            for (int k = 0; k < K; k++) begin
               for (int j = 0; j < H; j++) begin
                  output_add_o[(k*H+j)*FP8_W +: FP8_W] <= lane_sum_i[k][j];
               end
            end
         end
      end
   end

   // One pulse per job
   a_done_pulse: assert property (@(posedge clk) disable iff (rst_n)
      done_add_o |=> !done_add_o);

endmodule

// ==== hw/conv_accumulate_top.sv ====
`timescale 1ns/100ps

module conv_accumulate_top
   import cnn_pkg::*;
#(
   parameter int D = 4,
   parameter int H = 24,
   parameter int K = 8
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   done_convmul_i,
   input  logic [0:D*H*K*FP8_W-1] output_convmul_i,
   input  logic [0:K*FP8_W-1]     bias_i,
   output logic [0:H*K*FP8_W-1]   output_add_o,
   output logic                   done_add_o
);

   // Per-lane operand and sum rows
   fp8_t lane_operand [K][H];
   fp8_t lane_sum [K][H];

   acc_ctrl_if acc_ctrl ();

   slice_sequencer #(
      .D (D),
      .H (H),
      .K (K)
   ) u_seq (
      .clk              (clk),
      .rst_n            (rst_n),
      .done_convmul_i   (done_convmul_i),
      .output_convmul_i (output_convmul_i),
      .bias_i           (bias_i),
      .ctrl             (acc_ctrl.seq),
      .lane_operand_o   (lane_operand)
   );

   ////////////////////
   // Filter lanes
   ////////////////////

   for (genvar k = 0; k < K; k++) begin : g_lane
      filter_accumulator #(
         .H (H)
      ) u_lane (
         .clk        (clk),
         .rst_n      (rst_n),
         .ctrl       (acc_ctrl.lane),
         .operand_i  (lane_operand[k]),
         .lane_sum_o (lane_sum[k])
      );
   end

   result_collector #(
      .H (H),
      .K (K)
   ) u_collect (
      .clk          (clk),
      .rst_n        (rst_n),
      .ctrl         (acc_ctrl.lane),
      .lane_sum_i   (lane_sum),
      .output_add_o (output_add_o),
      .done_add_o   (done_add_o)
   );

endmodule

// ==== include/fp8_model.svh ====
`ifndef FP8_MODEL_SVH
`define FP8_MODEL_SVH

// Reference E4M3 addition, same guard width and truncation as the RTL adder
function automatic cnn_pkg::fp8_t fp8_add_ref(input cnn_pkg::fp8_t a, input cnn_pkg::fp8_t b);
   int unsigned mag_a;
   int unsigned mag_b;
   int unsigned mag_big;
   int unsigned mag_sml;
   int unsigned e_big;
   int unsigned e_sml;
   int unsigned sig_big;
   int unsigned sig_sml;
   int unsigned sum;
   int unsigned lead;
   int unsigned mant;
   int          e_res;
   bit          s_big;
   bit          s_sml;
   mag_a = (a[6:3] == 4'd0) ? 0 : int'(a[6:0]);
   mag_b = (b[6:3] == 4'd0) ? 0 : int'(b[6:0]);
   if (mag_a >= mag_b) begin
      mag_big = mag_a;
      mag_sml = mag_b;
      s_big   = a[7];
      s_sml   = b[7];
   end else begin
      mag_big = mag_b;
      mag_sml = mag_a;
      s_big   = b[7];
      s_sml   = a[7];
   end
   e_big   = mag_big >> 3;
   e_sml   = mag_sml >> 3;
   sig_big = (e_big == 0) ? 0 : ((8 + (mag_big & 7)) << 3);
   sig_sml = (e_sml == 0) ? 0 : ((8 + (mag_sml & 7)) << 3);
   sig_sml = sig_sml >> (e_big - e_sml);
   sum     = (s_big == s_sml) ? (sig_big + sig_sml) : (sig_big - sig_sml);
   if (sum == 0) begin
      return cnn_pkg::FP8_ZERO;
   end
   lead = 0;
   for (int i = 0; i < 8; i++) begin
      if (((sum >> i) & 1) != 0) begin
         lead = i;
      end
   end
   e_res = int'(e_big) + int'(lead) - 6;
   if (e_res < 1) begin
      return cnn_pkg::FP8_ZERO;
   end
   if (e_res > cnn_pkg::FP8_EXP_MAX) begin
      return {s_big, cnn_pkg::FP8_MAX_MAG};
   end
   mant = ((sum << (7 - lead)) >> 4) & 7;
   return {s_big, 4'(e_res), 3'(mant)};
endfunction

// Expected column j of filter k; D, H and K come from the including testbench
function automatic cnn_pkg::fp8_t fp8_column_ref(
   input logic [0:D*H*K*8-1] conv_vec,
   input logic [0:K*8-1]     bias_vec,
   input int                 k,
   input int                 j
);
   cnn_pkg::fp8_t acc;
   acc = cnn_pkg::FP8_ZERO;
   for (int d = 0; d < D; d++) begin
      acc = fp8_add_ref(acc, conv_vec[((k*D+d)*H+j)*8 +: 8]);
   end
   return fp8_add_ref(acc, bias_vec[k*8 +: 8]);
endfunction

// All K expected rows, packed like output_add_o
function automatic logic [0:H*K*8-1] fp8_rows_ref(
   input logic [0:D*H*K*8-1] conv_vec,
   input logic [0:K*8-1]     bias_vec
);
   logic [0:H*K*8-1] rows;
   rows = '0;
   for (int k = 0; k < K; k++) begin
      for (int j = 0; j < H; j++) begin
         rows[(k*H+j)*8 +: 8] = fp8_column_ref(conv_vec, bias_vec, k, j);
      end
   end
   return rows;
endfunction

`endif

// ==== sim/tb_conv_accumulate.sv ====
`timescale 1ns/100ps

module tb_conv_accumulate
   import cnn_pkg::*;
();

   localparam int D = 4;
   localparam int H = 6;
   localparam int K = 3;
   localparam int CONV_W = D * H * K * 8;
   localparam int BIAS_W = K * 8;
   localparam int ROW_W = H * K * 8;
   // Exact, random, saturation, flush and the three restart and hold jobs
   localparam int NUM_JOBS = 3 + 200 + 2 + 3;
   localparam int TIMEOUT_CYC = NUM_JOBS * 40 + 200;

   `include "fp8_model.svh"

   logic              clk;
   logic              rst_n;
   logic              done_convmul_i;
   logic [0:CONV_W-1] output_convmul_i;
   logic [0:BIAS_W-1] bias_i;
   logic [0:ROW_W-1]  output_add_o;
   logic              done_add_o;

   logic [0:ROW_W-1]  exp_row;
   logic              prev_done = 1'b0;
   int                cyc = 0;
   int                e0_cyc = 0;
   int                done_count = 0;
   int                n_checks = 0;
   int                n_errors = 0;
   int                n_tests = 0;

   conv_accumulate_top #(
      .D (D),
      .H (H),
      .K (K)
   ) uut (
      .clk              (clk),
      .rst_n            (rst_n),
      .done_convmul_i   (done_convmul_i),
      .output_convmul_i (output_convmul_i),
      .bias_i           (bias_i),
      .output_add_o     (output_add_o),
      .done_add_o       (done_add_o)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   ////////////////////
   // Helpers
   ////////////////////

   // Small non-negative integer exact in E4M3 up to 15
   function automatic fp8_t small_int_fp8(input int n);
      int e;
      e = 0;
      if (n == 0) begin
         return FP8_ZERO;
      end
      while ((n >> (e + 1)) != 0) begin
         e++;
      end
      return {1'b0, 4'(e + FP8_EXP_BIAS), 3'(((n << 3) >> e) - 8)};
   endfunction

   // Optional cancel makes slice 1 the negation of slice 0
   function automatic logic [0:CONV_W-1] random_tensor(input bit cancel);
      logic [0:CONV_W-1] t;
      for (int i = 0; i < D * H * K; i++) begin
         t[i*8 +: 8] = 8'($urandom);
      end
      if (cancel) begin
         for (int k = 0; k < K; k++) begin
            for (int j = 0; j < H; j++) begin
               t[((k*D+1)*H+j)*8 +: 8] = t[(k*D*H+j)*8 +: 8] ^ 8'h80;
            end
         end
      end
      return t;
   endfunction

   task automatic launch_job(input logic [0:CONV_W-1] conv, input logic [0:BIAS_W-1] bias,
                             input logic [0:ROW_W-1] want_row);
      @(posedge clk);
      output_convmul_i <= conv;
      bias_i           <= bias;
      done_convmul_i   <= 1'b1;
      exp_row = want_row;
      // E0 is the next rising edge
      e0_cyc = cyc + 2;
      @(posedge clk);
      done_convmul_i <= 1'b0;
   endtask

   task automatic wait_for_done(input int prev);
      while (done_count == prev) begin
         @(posedge clk);
      end
   endtask

   task automatic run_job(input logic [0:CONV_W-1] conv, input logic [0:BIAS_W-1] bias,
                          input logic [0:ROW_W-1] want_row);
      int prev;
      prev = done_count;
      launch_job(conv, bias, want_row);
      wait_for_done(prev);
   endtask

   task automatic report_test(input string name, input int err_mark);
      n_tests++;
      if (n_errors == err_mark) begin
         $display("Test %0d %s: ok", n_tests, name);
      end else begin
         $display("Test %0d %s: %0d errors", n_tests, name, n_errors - err_mark);
      end
   endtask

   ////////////////////
   // Compare
   ////////////////////

   // Sampled at the falling edge away from the DUT updates
   always @(negedge clk) begin
      if (done_add_o) begin
         done_count = done_count + 1;
         n_checks = n_checks + 1;
         if (prev_done) begin
            $display("** Error at %0t: done_add_o high for two cycles", $time);
            n_errors = n_errors + 1;
         end
         if (cyc - e0_cyc != D + 3) begin
            $display("** Error at %0t: done_add_o after %0d cycles, expected %0d",
                     $time, cyc - e0_cyc, D + 3);
            n_errors = n_errors + 1;
         end
         for (int k = 0; k < K; k++) begin
            for (int j = 0; j < H; j++) begin
               n_checks = n_checks + 1;
               if (output_add_o[(k*H+j)*8 +: 8] !== exp_row[(k*H+j)*8 +: 8]) begin
                  $display("** Error at %0t: filter %0d column %0d expected %02h actual %02h",
                           $time, k, j, exp_row[(k*H+j)*8 +: 8],
                           output_add_o[(k*H+j)*8 +: 8]);
                  n_errors = n_errors + 1;
               end
            end
         end
      end
      prev_done = done_add_o;
   end

   initial begin
      repeat (TIMEOUT_CYC) @(posedge clk);
      $display("Timeout after %0d cycles, done_add_o never arrived", TIMEOUT_CYC);
      $display("Checks failed");
      $finish;
   end

   ////////////////////
   // Stimulus
   ////////////////////

   initial begin
      logic [0:CONV_W-1] conv;
      logic [0:BIAS_W-1] bias;
      logic [0:ROW_W-1]  want;
      logic [0:ROW_W-1]  held;
      int                total;
      int                term;
      int                val;
      int                err_mark;
      int                prev;
      void'($urandom(32396));
      rst_n            = 1'b1;
      done_convmul_i   = 1'b0;
      output_convmul_i = '0;
      bias_i           = '0;

      err_mark = n_errors;
      repeat (2) @(posedge clk);
      rst_n <= 1'b0;
      @(negedge clk);
      n_checks++;
      if (done_add_o !== 1'b0 || output_add_o !== '0) begin
         $display("** Error at %0t: outputs not zero after reset, done %b", $time, done_add_o);
         n_errors++;
      end
      report_test("reset state", err_mark);

      // Integer sums stay at or below 15, so every step is exact
      err_mark = n_errors;
      for (int job = 0; job < 3; job++) begin
         for (int k = 0; k < K; k++) begin
            val = int'($urandom % 4);
            bias[k*8 +: 8] = small_int_fp8(val);
            for (int j = 0; j < H; j++) begin
               total = val;
               for (int d = 0; d < D; d++) begin
                  term = int'($urandom % 4);
                  conv[((k*D+d)*H+j)*8 +: 8] = small_int_fp8(term);
                  total += term;
               end
               want[(k*H+j)*8 +: 8] = small_int_fp8(total);
            end
         end
         run_job(conv, bias, want);
      end
      report_test("exact sums and timing", err_mark);

      err_mark = n_errors;
      for (int job = 0; job < 200; job++) begin
         conv = random_tensor(($urandom % 4) == 0);
         for (int k = 0; k < K; k++) begin
            bias[k*8 +: 8] = 8'($urandom);
         end
         run_job(conv, bias, fp8_rows_ref(conv, bias));
      end
      report_test("random operands", err_mark);

      // 240 added five times runs past 480
      // Odd filters are negative
      err_mark = n_errors;
      for (int k = 0; k < K; k++) begin
         bias[k*8 +: 8] = (k % 2 == 0) ? 8'h77 : 8'hF7;
         for (int i = 0; i < D * H; i++) begin
            conv[(k*D*H+i)*8 +: 8] = bias[k*8 +: 8];
         end
         for (int j = 0; j < H; j++) begin
            want[(k*H+j)*8 +: 8] = (k % 2 == 0) ? 8'h7F : 8'hFF;
         end
      end
      run_job(conv, bias, want);
      // Flushed slices leave only the bias
      for (int k = 0; k < K; k++) begin
         bias[k*8 +: 8] = {1'($urandom), 4'(1 + $urandom % 15), 3'($urandom)};
         for (int i = 0; i < D * H; i++) begin
            conv[(k*D*H+i)*8 +: 8] = 8'($urandom) & 8'h87;
         end
         for (int j = 0; j < H; j++) begin
            want[(k*H+j)*8 +: 8] = bias[k*8 +: 8];
         end
      end
      run_job(conv, bias, want);
      report_test("saturation and flushing", err_mark);

      // Second strobe lands while the first job is accumulating
      err_mark = n_errors;
      prev = done_count;
      conv = random_tensor(1'b0);
      bias = BIAS_W'($urandom);
      launch_job(conv, bias, fp8_rows_ref(conv, bias));
      @(posedge clk);
      conv = random_tensor(1'b1);
      bias = BIAS_W'($urandom);
      launch_job(conv, bias, fp8_rows_ref(conv, bias));
      wait_for_done(prev);
      held = exp_row;
      // Next job runs while the previous row stays on the output
      conv = random_tensor(1'b0);
      bias = BIAS_W'($urandom);
      launch_job(conv, bias, fp8_rows_ref(conv, bias));
      repeat (D + 3) begin
         @(negedge clk);
         n_checks++;
         if (done_add_o !== 1'b0 || output_add_o !== held) begin
            $display("** Error at %0t: output row not held until the next done", $time);
            n_errors++;
         end
      end
      wait_for_done(prev + 1);
      if (done_count != prev + 2) begin
         $display("** Error at %0t: %0d done strobes for two completed jobs, expected 2",
                  $time, done_count - prev);
         n_errors++;
      end
      report_test("restart and hold", err_mark);

      $display("Tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
      if (n_errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+include
hw/cnn_pkg.sv
hw/acc_ctrl_if.sv
hw/fp8_adder.sv
hw/slice_sequencer.sv
hw/filter_accumulator.sv
hw/result_collector.sv
hw/conv_accumulate_top.sv
sim/tb_conv_accumulate.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_conv_accumulate
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = All checks passed

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
